/* common/loader_pkg.sv */
// Shared widths for the ROM download path
// Host request and Wishbone master structs, controller state enum

package loader_pkg;

	////////////////////
	// Widths
	////////////////////

	// One host data halfword
	localparam int HALF_WIDTH = 16;

	// One packed ROM word, two halfwords
	localparam int WORD_WIDTH = 32;

	// Host byte address
	localparam int IOCTL_ADDR_WIDTH = 25;

	// Wishbone word address, byte address without its two low bits
	localparam int WB_ADDR_WIDTH = IOCTL_ADDR_WIDTH - 2;

	////////////////////
	// Bus structs
	////////////////////

	// One host request as seen on the ioctl port
	typedef struct packed {
		// High for the whole transfer
		logic download;
		// Write pulse, one or more host cycles
		logic wr;
		// Byte address of the halfword
		logic [IOCTL_ADDR_WIDTH-1:0] addr;
		// Halfword payload
		logic [HALF_WIDTH-1:0] dout;
	} ioctl_t;

	// Master-driven Wishbone classic signals
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		// Word address
		logic [WB_ADDR_WIDTH-1:0] adr;
		logic [WORD_WIDTH-1:0] dat;
		// Full words only, so always all ones
		logic [WORD_WIDTH/8-1:0] sel;
	} wb_master_t;

	////////////////////
	// Controller states
	////////////////////

	typedef enum logic [1:0] {
		// Core in reset, counting after hardware_reset or a download
		st_settle,
		// Core running
		st_run,
		// Download started, host stalled while counting
		st_hold,
		// Download in progress
		st_load
	} ctrl_state_e;

endpackage

/* hdl/download_control.sv */
// Reset and host stall sequencing around ROM downloads
// FSM with one shared hold counter

`timescale 1ns/100ps

module download_control #(
	// Cycles spent in st_settle and in st_hold
	parameter int HOLD_CYCLES = 255
) (
	input logic clk_sys,
	input logic hardware_reset,

	// Synchronized download flag from the host
	input logic download,

	// Packer has a word waiting for its acknowledge
	input logic packer_busy,

	// Packer may take halfwords
	output logic load_enable,

	// Core held in reset
	output logic core_reset,

	// Stall the host
	output logic ioctl_wait
);

	////////////////////
	// Counter sizing
	////////////////////

	// Wide enough to hold HOLD_CYCLES itself
	localparam int CNT_WIDTH = $clog2(HOLD_CYCLES + 1);

	// Last count of a hold period
	localparam logic [CNT_WIDTH-1:0] CNT_LAST = CNT_WIDTH'(HOLD_CYCLES - 1);

	////////////////////
	// State
	////////////////////

	loader_pkg::ctrl_state_e state_q;
	loader_pkg::ctrl_state_e state_d;

	// Hold counter, reused by st_settle and st_hold
	logic [CNT_WIDTH-1:0] cnt_q;
	logic [CNT_WIDTH-1:0] cnt_d;

	// Current hold period ends this cycle
	logic hold_done;

	assign hold_done = (cnt_q == CNT_LAST);

	// hardware_reset lands in st_settle with a fresh count
	always_ff @(posedge clk_sys) begin
		if (hardware_reset) begin
			state_q <= loader_pkg::st_settle;
			cnt_q <= '0;
		end else begin
			state_q <= state_d;
			cnt_q <= cnt_d;
		end
	end

	////////////////////
	// Next state
	////////////////////

	always_comb begin
		state_d = state_q;
		// Counter reads zero on entry to every state
		cnt_d = '0;

		case (state_q)
			// Core still in reset after power-up or after a download
			loader_pkg::st_settle: begin
				if (hold_done) begin
					state_d = loader_pkg::st_run;
				end else begin
					cnt_d = cnt_q + 1'b1;
				end
			end

			// Download level seen high, so a transfer has started
			loader_pkg::st_run: begin
				if (download) begin
					state_d = loader_pkg::st_hold;
				end
			end

			// Give the core time to settle in reset before data flows
			loader_pkg::st_hold: begin
				if (hold_done) begin
					state_d = loader_pkg::st_load;
				end else begin
					cnt_d = cnt_q + 1'b1;
				end
			end

			// Halfwords flow until the host drops download
			loader_pkg::st_load: begin
				if (!download) begin
					state_d = loader_pkg::st_settle;
				end
			end

			default: begin
				state_d = loader_pkg::st_settle;
			end
		endcase
	end

	////////////////////
	// Outputs
	////////////////////

	// Core runs only in st_run
	assign core_reset = (state_q != loader_pkg::st_run);

	// Packer is live only during the load phase
	assign load_enable = (state_q == loader_pkg::st_load);

	// Stall during the hold time and while a word waits for ack
	assign ioctl_wait = (state_q == loader_pkg::st_hold) ||
		((state_q == loader_pkg::st_load) && packer_busy);

endmodule

/* hdl/rom_loader_top.sv */
// ROM download top level
// Synchronizer, halfword packer and reset controller

`timescale 1ns/100ps

module rom_loader_top #(
	// Hold time in clk_sys cycles around each download
	parameter int HOLD_CYCLES = 255
) (
	input logic clk_sys,
	input logic hardware_reset,

	// Host side, in the host clock domain
	input loader_pkg::ioctl_t ioctl,
	output logic ioctl_wait,

	// ROM storage, Wishbone classic master
	output loader_pkg::wb_master_t wb,
	input logic wb_ack,

	// Reset for the core fed by this ROM
	output logic core_reset
);

	////////////////////
	// Internal wires
	////////////////////

	// Host request after the two-stage synchronizer
	loader_pkg::ioctl_t ioctl_synced;

	// One clk_sys pulse per host write
	logic wr_rise;

	// Packer may accept halfwords
	logic load_enable;

	// Packed word waiting for its acknowledge
	logic packer_busy;

	////////////////////
	// Clock crossing
	////////////////////

	ioctl_sync u_ioctl_sync (
		.clk_sys        (clk_sys),
		.hardware_reset (hardware_reset),
		.ioctl          (ioctl),
		.ioctl_synced   (ioctl_synced),
		.wr_rise        (wr_rise)
	);

	////////////////////
	// Word packing
	////////////////////

	word_packer u_word_packer (
		.clk_sys        (clk_sys),
		.hardware_reset (hardware_reset),
		.ioctl_synced   (ioctl_synced),
		.wr_rise        (wr_rise),
		.load_enable    (load_enable),
		.wb             (wb),
		.wb_ack         (wb_ack),
		.packer_busy    (packer_busy)
	);

	////////////////////
	// Reset sequencing
	////////////////////

	// Controller sees download only after the synchronizer
	download_control #(
		.HOLD_CYCLES (HOLD_CYCLES)
	) u_download_control (
		.clk_sys        (clk_sys),
		.hardware_reset (hardware_reset),
		.download       (ioctl_synced.download),
		.packer_busy    (packer_busy),
		.load_enable    (load_enable),
		.core_reset     (core_reset),
		.ioctl_wait     (ioctl_wait)
	);

endmodule

/* list.f */
common/loader_pkg.sv
rom_loader/ioctl_sync.sv
rom_loader/word_packer.sv
hdl/download_control.sv
hdl/rom_loader_top.sv
sim/rom_loader_checker.sv
sim/rom_loader_tb.sv

/* rom_loader/ioctl_sync.sv */
// Two-stage synchronizer of the host ioctl request
// Rising-edge detection of the write pulse

`timescale 1ns/100ps

module ioctl_sync (
	input logic clk_sys,
	input logic hardware_reset,

	// Raw request from the host clock domain
	input loader_pkg::ioctl_t ioctl,

	// Request in clk_sys, two cycles behind the input
	output loader_pkg::ioctl_t ioctl_synced,

	// One cycle pulse, one cycle after synced wr rises
	output logic wr_rise
);

	////////////////////
	// Sync stages
	////////////////////

	// First stage may go metastable
	loader_pkg::ioctl_t stage1_q;
	loader_pkg::ioctl_t stage2_q;

	// Third stage of wr, only for edge detection
	logic wr_stage3_q;

	// Registered edge pulse
	logic wr_rise_q;

	always_ff @(posedge clk_sys) begin
		if (hardware_reset) begin
			stage1_q <= '0;
			stage2_q <= '0;
			wr_stage3_q <= 1'b0;
			wr_rise_q <= 1'b0;
		end else begin
			stage1_q <= ioctl;
			stage2_q <= stage1_q;
			wr_stage3_q <= stage2_q.wr;
			// New write when stage 2 is high and stage 3 still low
			wr_rise_q <= stage2_q.wr & ~wr_stage3_q;
		end
	end

	assign ioctl_synced = stage2_q;
	assign wr_rise = wr_rise_q;

endmodule

/* rom_loader/word_packer.sv */
// Packs pairs of host halfwords into 32-bit ROM words
// Wishbone classic single-write master, one word in flight

`timescale 1ns/100ps

module word_packer (
	input logic clk_sys,
	input logic hardware_reset,

	// Synchronized host request
	input loader_pkg::ioctl_t ioctl_synced,

	// One pulse per host write
	input logic wr_rise,

	// Low outside the load phase
	input logic load_enable,

	// Wishbone master side
	output loader_pkg::wb_master_t wb,
	input logic wb_ack,

	// Word built and not yet acknowledged
	output logic packer_busy
);

	////////////////////
	// Registers
	////////////////////

	// Low half when clear, high half when set
	logic half_idx_q;

	// Bus cycle open
	logic active_q;

	// Word address from the first halfword
	logic [loader_pkg::WB_ADDR_WIDTH-1:0] adr_q;

	// Word under assembly
	logic [loader_pkg::WORD_WIDTH-1:0] dat_q;

	// Halfword taken this cycle
	logic accept;

	// Writes during an open bus cycle are ignored
	assign accept = wr_rise & load_enable & ~active_q;

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (hardware_reset) begin
			half_idx_q <= 1'b0;
			active_q <= 1'b0;
		end else begin
			// Close the cycle the clock after ack
			if (active_q && wb_ack) begin
				active_q <= 1'b0;
			end

			// Leaving the load phase drops a half-built pair
			if (!load_enable) begin
				half_idx_q <= 1'b0;
			end else if (accept) begin
				half_idx_q <= ~half_idx_q;
				// Second half completes the word
				if (half_idx_q) begin
					active_q <= 1'b1;
				end
			end
		end
	end

	////////////////////
	// Payload
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			if (!half_idx_q) begin
				dat_q[loader_pkg::HALF_WIDTH-1:0] <= ioctl_synced.dout;
				// Byte address to word address
				adr_q <= ioctl_synced.addr[loader_pkg::IOCTL_ADDR_WIDTH-1:2];
			end else begin
				dat_q[loader_pkg::WORD_WIDTH-1:loader_pkg::HALF_WIDTH] <= ioctl_synced.dout;
			end
		end
	end

	// Busy from the completing wr_rise through the ack cycle
	assign packer_busy = active_q | (accept & half_idx_q);

	// Address and data stay put while the cycle is open
	always_comb begin
		wb.cyc = active_q;
		wb.stb = active_q;
		wb.we = active_q;
		wb.adr = adr_q;
		wb.dat = dat_q;
		wb.sel = '1;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the ROM loader simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/rom_loader_sim

echo "Building with Verilator"
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module rom_loader_tb -o rom_loader_sim -f list.f
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

echo "Running simulation"
"$SIM" +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	echo "Simulation reported failure, see $LOG"
	exit 1
fi

echo "Simulation finished without failure"
exit 0

/* sim/rom_loader_checker.sv */
// Bound protocol checks for the ROM loader
// Wishbone classic handshake and reset state

`timescale 1ns/100ps

module rom_loader_checker (
	input logic clk_sys,
	input logic hardware_reset,
	input loader_pkg::wb_master_t wb,
	input logic wb_ack,
	input logic core_reset,
	input logic ioctl_wait
);

	// Count of failed assertions
	int fail_count = 0;

	// Outputs settle to their reset values one clock into hardware_reset
	a_reset_state: assert property (@(posedge clk_sys)
		hardware_reset |=> (core_reset && !ioctl_wait && !wb.cyc && !wb.stb))
		else begin
			fail_count++;
			$error("Outputs not in reset state after hardware_reset");
		end

	////////////////////
	// Wishbone classic
	////////////////////

	a_stb_cyc: assert property (@(posedge clk_sys) disable iff (hardware_reset)
		wb.stb |-> wb.cyc)
		else begin
			fail_count++;
			$error("stb high without cyc");
		end

	// Cycle closes right after the ack
	a_drop_after_ack: assert property (@(posedge clk_sys) disable iff (hardware_reset)
		(wb.stb && wb_ack) |=> (!wb.cyc && !wb.stb))
		else begin
			fail_count++;
			$error("cyc or stb still high the cycle after ack");
		end

	a_hold_stable: assert property (@(posedge clk_sys) disable iff (hardware_reset)
		(wb.stb && !wb_ack) |=> (wb.stb && $stable(wb.adr) && $stable(wb.dat)))
		else begin
			fail_count++;
			$error("Write dropped or changed before ack");
		end

	// Writes only while the core sits in reset
	a_stb_in_reset: assert property (@(posedge clk_sys) disable iff (hardware_reset)
		wb.stb |-> core_reset)
		else begin
			fail_count++;
			$error("Write strobed while core running");
		end

endmodule

/* sim/rom_loader_tb.sv */
// Testbench for the ROM download top level
// Host writer, Wishbone slave, scoreboard and protocol monitor

`timescale 1ns/100ps

module rom_loader_tb;

	////////////////////
	// Settings
	////////////////////

	localparam int HOLD_CYCLES = 16;
	// Halfwords in the single download, six packed words
	localparam int NUM_HALVES = 12;
	// Whole run needs about 300 cycles with the longest ack delays
	localparam int MAX_CYCLES = 2000;
	localparam logic [loader_pkg::IOCTL_ADDR_WIDTH-1:0] BASE_ADDR = 'h400;
	localparam logic [loader_pkg::IOCTL_ADDR_WIDTH-1:0] ADDR_STEP = 'd2;

	logic clk_sys;
	logic hardware_reset;
	loader_pkg::ioctl_t ioctl;
	logic ioctl_wait;
	loader_pkg::wb_master_t wb;
	logic wb_ack;
	logic core_reset;

	int seed;
	int errors;
	int cycle_count = 0;
	// High once the host has dropped download
	logic dl_done;

	// Expected writes, oldest first
	logic [loader_pkg::WB_ADDR_WIDTH-1:0] exp_adr_q[$];
	logic [loader_pkg::WORD_WIDTH-1:0] exp_dat_q[$];

	// Last cycle's bus, for the hold checks
	logic prev_stb;
	logic prev_ack;
	logic prev_core_reset;
	logic [loader_pkg::WB_ADDR_WIDTH-1:0] prev_adr;
	logic [loader_pkg::WORD_WIDTH-1:0] prev_dat;

	// Slave side handshake
	logic in_xfer;
	int ack_count;
	int rnd;

	rom_loader_top #(
		.HOLD_CYCLES (HOLD_CYCLES)
	) dut (
		.clk_sys        (clk_sys),
		.hardware_reset (hardware_reset),
		.ioctl          (ioctl),
		.ioctl_wait     (ioctl_wait),
		.wb             (wb),
		.wb_ack         (wb_ack),
		.core_reset     (core_reset)
	);

	bind rom_loader_top rom_loader_checker u_checker (
		.clk_sys        (clk_sys),
		.hardware_reset (hardware_reset),
		.wb             (wb),
		.wb_ack         (wb_ack),
		.core_reset     (core_reset),
		.ioctl_wait     (ioctl_wait)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#10 clk_sys = ~clk_sys;
		end
	end

	////////////////////
	// Helpers
	////////////////////

	// One clock, inputs move 2 ns after the edge
	task automatic step();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic log_failure(input string msg);
		errors++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	// Host write of one halfword, honoring ioctl_wait
	task automatic send_halfword(input logic [loader_pkg::IOCTL_ADDR_WIDTH-1:0] addr,
		input logic [loader_pkg::HALF_WIDTH-1:0] data);
		while (ioctl_wait) begin
			step();
		end
		ioctl.addr = addr;
		ioctl.dout = data;
		step();
		ioctl.wr = 1'b1;
		step();
		ioctl.wr = 1'b0;
		// Write reaches the packer 3 cycles later, then ioctl_wait is current
		repeat (4) step();
	endtask

	////////////////////
	// Wishbone slave
	////////////////////

	initial begin
		wb_ack = 1'b0;
		in_xfer = 1'b0;
		ack_count = 0;
		forever begin
			@(posedge clk_sys);
			if (wb_ack) begin
				// Ack seen at this edge
				#2 wb_ack = 1'b0;
				in_xfer = 1'b0;
			end else if (wb.stb && !hardware_reset) begin
				if (!in_xfer) begin
					in_xfer = 1'b1;
					rnd = $random(seed);
					ack_count = (rnd & 32'h7fff_ffff) % 6;
				end
				if (ack_count == 0) begin
					#2 wb_ack = 1'b1;
				end else begin
					ack_count--;
				end
			end
		end
	end

	////////////////////
	// Bus monitor
	////////////////////

	always @(posedge clk_sys) begin
		if (hardware_reset) begin
			prev_stb <= 1'b0;
			prev_ack <= 1'b0;
			prev_core_reset <= 1'b1;
		end else begin
			// Scoreboard, one entry per acknowledged write
			if (wb.stb && wb_ack) begin
				assert (exp_adr_q.size() != 0) else log_failure("write with no word expected");
				if (exp_adr_q.size() != 0) begin
					assert (wb.adr == exp_adr_q[0]) else
						log_failure($sformatf("adr %h, expected %h", wb.adr, exp_adr_q[0]));
					assert (wb.dat == exp_dat_q[0]) else
						log_failure($sformatf("dat %h, expected %h", wb.dat, exp_dat_q[0]));
					exp_adr_q.delete(0);
					exp_dat_q.delete(0);
				end
			end
			if (wb.stb) begin
				assert (wb.we && wb.sel == '1) else log_failure("write without we or full sel");
				assert (!dl_done) else log_failure("write strobed after download ended");
			end
			// Back-pressure keeps the word and the host stall in place
			if (prev_stb && !prev_ack && wb.stb) begin
				assert (wb.adr == prev_adr && wb.dat == prev_dat) else
					log_failure("adr or dat moved while waiting for ack");
			end
			if (wb.stb && !wb_ack) begin
				assert (ioctl_wait) else log_failure("ioctl_wait low while ack pending");
			end
			// Reset only returns for a download
			if (core_reset && !prev_core_reset) begin
				assert (ioctl.download) else log_failure("core_reset rose with download low");
			end
			prev_stb <= wb.stb;
			prev_ack <= wb_ack;
			prev_adr <= wb.adr;
			prev_dat <= wb.dat;
			prev_core_reset <= core_reset;
		end
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Run timed out after %0d cycles", cycle_count);
			$display("Errors: testbench %0d, checker %0d", errors, dut.u_checker.fail_count);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		int i;
		int settle_len;
		int hold_len;
		logic [31:0] host_rnd;
		logic [loader_pkg::IOCTL_ADDR_WIDTH-1:0] addr;
		logic [loader_pkg::IOCTL_ADDR_WIDTH-1:0] first_addr;
		logic [loader_pkg::HALF_WIDTH-1:0] first_half;

		seed = 9;
		errors = 0;
		dl_done = 1'b0;
		hardware_reset = 1'b1;
		ioctl = '0;
		repeat (10) @(posedge clk_sys);
		#2 hardware_reset = 1'b0;
		assert (core_reset && !ioctl_wait && !wb.cyc && !wb.stb) else
			log_failure("outputs not in reset state after hardware_reset");

		// Core leaves reset after the settle time
		settle_len = 0;
		while (core_reset) begin
			settle_len++;
			step();
		end
		assert (settle_len >= HOLD_CYCLES) else log_failure("settle after reset too short");
		repeat (20) step();

		// Download start, host held off for the hold time
		ioctl.download = 1'b1;
		while (!ioctl_wait) begin
			step();
		end
		assert (core_reset) else log_failure("core_reset low during hold");
		hold_len = 0;
		while (ioctl_wait) begin
			hold_len++;
			step();
		end
		assert (hold_len >= HOLD_CYCLES) else log_failure("hold time too short");

		addr = BASE_ADDR;
		for (i = 0; i < NUM_HALVES; i++) begin
			host_rnd = $random(seed);
			if (i % 2 == 0) begin
				first_addr = addr;
				first_half = host_rnd[15:0];
			end else begin
				// Word address is the first byte address over 4
				exp_adr_q.push_back(first_addr[loader_pkg::IOCTL_ADDR_WIDTH-1:2]);
				exp_dat_q.push_back({host_rnd[15:0], first_half});
			end
			send_halfword(addr, host_rnd[15:0]);
			addr = addr + ADDR_STEP;
		end

		// Last word acknowledged before download drops
		while (ioctl_wait) begin
			step();
		end
		ioctl.download = 1'b0;
		dl_done = 1'b1;
		settle_len = 0;
		while (core_reset) begin
			settle_len++;
			step();
		end
		assert (settle_len >= HOLD_CYCLES) else log_failure("settle after download too short");
		repeat (10) step();
		assert (exp_adr_q.size() == 0) else log_failure("expected writes never appeared");

		$display("Errors: testbench %0d, checker %0d", errors, dut.u_checker.fail_count);
		if (errors == 0 && dut.u_checker.fail_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
